//--- verilog/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// integer data word width
`define RV_XLEN 32

// register index width
`define RV_REG_ADDR_W 5

// architectural registers x0 to x31
`define RV_NUM_REGS 32

// one instruction word per strobe
`define RV_INSTR_W 32

`endif

//--- verilog/rv_pkg.sv
`include "rv_macros.svh"

package rv_pkg;

    // major opcodes the core still executes
    typedef enum logic [6:0] {
        op_lui = 7'b0110111,
        op_imm = 7'b0010011,
        op_reg = 7'b0110011
    } rv_opcode_e;

    // funct3 of the integer arithmetic group
    // shared by the register and immediate forms
    typedef enum logic [2:0] {
        f3_add  = 3'b000,
        f3_sll  = 3'b001,
        f3_slt  = 3'b010,
        f3_sltu = 3'b011,
        f3_xor  = 3'b100,
        f3_sr   = 3'b101,
        f3_or   = 3'b110,
        f3_and  = 3'b111
    } arith_funct3_e;

    // operations the execute stage can perform
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        // lui just forwards the upper immediate
        alu_pass_b
    } alu_op_e;

    // decode to execute boundary
    typedef struct packed {
        logic                      valid;
        alu_op_e                   alu_op;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_REG_ADDR_W-1:0] rs1_addr;
        logic [`RV_REG_ADDR_W-1:0] rs2_addr;
        logic [`RV_XLEN-1:0]       rs1_data;
        logic [`RV_XLEN-1:0]       rs2_data;
        logic [`RV_XLEN-1:0]       imm;
        // second alu operand comes from imm
        logic                      use_imm;
    } id_ex_t;

    // retired result, also the register file write port
    typedef struct packed {
        logic                      valid;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       data;
    } commit_t;

endpackage : rv_pkg

//--- verilog/alu.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module alu (
    input  rv_pkg::alu_op_e     op_i,
    input  logic [`RV_XLEN-1:0] a_i,
    input  logic [`RV_XLEN-1:0] b_i,
    output logic [`RV_XLEN-1:0] f_o
);

    localparam int SHAMT_W = $clog2(`RV_XLEN);

    // only the low bits count as shift amount
    logic [SHAMT_W-1:0] shamt;

    assign shamt = b_i[SHAMT_W-1:0];

    always_comb begin
        case (op_i)
            rv_pkg::alu_add:    f_o = a_i + b_i;
            rv_pkg::alu_sub:    f_o = a_i - b_i;
            rv_pkg::alu_sll:    f_o = a_i << shamt;
            // compares give 0 or 1
            rv_pkg::alu_slt:    f_o = {{(`RV_XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            rv_pkg::alu_sltu:   f_o = {{(`RV_XLEN-1){1'b0}}, a_i < b_i};
            rv_pkg::alu_xor:    f_o = a_i ^ b_i;
            rv_pkg::alu_srl:    f_o = a_i >> shamt;
            // sign bit fills from the left
            rv_pkg::alu_sra:    f_o = $unsigned($signed(a_i) >>> shamt);
            rv_pkg::alu_or:     f_o = a_i | b_i;
            rv_pkg::alu_and:    f_o = a_i & b_i;
            rv_pkg::alu_pass_b: f_o = b_i;
            default:            f_o = '0;
        endcase
    end

endmodule : alu

//--- verilog/reg_file.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module reg_file (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  rv_pkg::commit_t           wr_i,
    input  logic [`RV_REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`RV_REG_ADDR_W-1:0] rs2_addr_i,
    output logic [`RV_XLEN-1:0]       rs1_data_o,
    output logic [`RV_XLEN-1:0]       rs2_data_o
);

    logic [`RV_XLEN-1:0] regs_q [`RV_NUM_REGS];
    logic                wr_en;

    // x0 is never written
    assign wr_en = wr_i.valid && (wr_i.rd != '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wr_i.rd] <= wr_i.data;
        end
    end

    // x0 reads zero, a write in flight bypasses the array
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                        (wr_en && (wr_i.rd == rs1_addr_i)) ? wr_i.data :
                        regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                        (wr_en && (wr_i.rd == rs2_addr_i)) ? wr_i.data :
                        regs_q[rs2_addr_i];

endmodule : reg_file

//--- verilog/decode_stage.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   instr_valid_i,
    input  logic [`RV_INSTR_W-1:0] instr_i,

    // writeback from the commit register
    input  rv_pkg::commit_t        wb_i,

    output rv_pkg::id_ex_t         id_ex_o
);

    logic [`RV_INSTR_W-1:0]    instr_q;
    logic                      instr_valid_q;

    rv_pkg::rv_opcode_e        opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_XLEN-1:0]       i_imm;
    logic [`RV_XLEN-1:0]       u_imm;
    logic [`RV_XLEN-1:0]       rs1_data;
    logic [`RV_XLEN-1:0]       rs2_data;

    logic                      op_known;
    logic                      use_imm;
    logic [`RV_XLEN-1:0]       imm;
    rv_pkg::alu_op_e           alu_op;

    // maps funct3 to an alu op
    // bit 30 picks sub only in the register form, sra in both
    function automatic rv_pkg::alu_op_e arith_op(input logic [2:0] f3,
                                                 input logic       alt,
                                                 input logic       is_reg);
        rv_pkg::alu_op_e op;
        case (rv_pkg::arith_funct3_e'(f3))
            rv_pkg::f3_add:  op = (is_reg && alt) ? rv_pkg::alu_sub : rv_pkg::alu_add;
            rv_pkg::f3_sll:  op = rv_pkg::alu_sll;
            rv_pkg::f3_slt:  op = rv_pkg::alu_slt;
            rv_pkg::f3_sltu: op = rv_pkg::alu_sltu;
            rv_pkg::f3_xor:  op = rv_pkg::alu_xor;
            rv_pkg::f3_sr:   op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            rv_pkg::f3_or:   op = rv_pkg::alu_or;
            default:         op = rv_pkg::alu_and;
        endcase
        return op;
    endfunction

    // valid is control, the word itself only loads with its strobe
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            instr_valid_q <= 1'b0;
        end else begin
            instr_valid_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            instr_q <= instr_i;
        end
    end

    // fixed rv32i field positions
    assign opcode = rv_pkg::rv_opcode_e'(instr_q[6:0]);
    assign rd     = instr_q[11:7];
    assign funct3 = instr_q[14:12];
    assign rs1    = instr_q[19:15];
    assign rs2    = instr_q[24:20];
    assign funct7 = instr_q[31:25];

    // i-type sign extended, u-type fills the upper bits
    assign i_imm = {{(`RV_XLEN-12){instr_q[31]}}, instr_q[31:20]};
    assign u_imm = {instr_q[31:12], 12'h000};

    always_comb begin
        op_known = 1'b1;
        use_imm  = 1'b0;
        imm      = i_imm;
        alu_op   = rv_pkg::alu_add;
        case (opcode)
            rv_pkg::op_reg: begin
                alu_op = arith_op(funct3, funct7[5], 1'b1);
            end
            rv_pkg::op_imm: begin
                use_imm = 1'b1;
                alu_op  = arith_op(funct3, funct7[5], 1'b0);
            end
            rv_pkg::op_lui: begin
                use_imm = 1'b1;
                imm     = u_imm;
                alu_op  = rv_pkg::alu_pass_b;
            end
            // anything else is dropped here
            default: op_known = 1'b0;
        endcase
    end

    // a commit in this same cycle reaches the read ports directly
    reg_file i_reg_file (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wr_i       (wb_i),
        .rs1_addr_i (rs1),
        .rs2_addr_i (rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // ID/EX register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o.valid    <= instr_valid_q && op_known;
            id_ex_o.alu_op   <= alu_op;
            id_ex_o.rd       <= rd;
            id_ex_o.rs1_addr <= rs1;
            id_ex_o.rs2_addr <= rs2;
            id_ex_o.rs1_data <= rs1_data;
            id_ex_o.rs2_data <= rs2_data;
            id_ex_o.imm      <= imm;
            id_ex_o.use_imm  <= use_imm;
        end
    end

endmodule : decode_stage

//--- verilog/execute_stage.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module execute_stage (
    input  logic            clk,
    input  logic            rst_n_i,
    input  rv_pkg::id_ex_t  id_ex_i,
    output rv_pkg::commit_t commit_o
);

    logic                fwd_ok;
    logic                fwd_rs1;
    logic                fwd_rs2;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_f;

    // previous instruction sits in the commit register
    // and has not reached the register file yet
    assign fwd_ok  = commit_o.valid && (commit_o.rd != '0);
    assign fwd_rs1 = fwd_ok && (commit_o.rd == id_ex_i.rs1_addr);
    assign fwd_rs2 = fwd_ok && (commit_o.rd == id_ex_i.rs2_addr);

    // forwarding muxes
    assign rs1_val = fwd_rs1 ? commit_o.data : id_ex_i.rs1_data;
    assign rs2_val = fwd_rs2 ? commit_o.data : id_ex_i.rs2_data;

    // immediate forms and lui take the immediate as b
    assign alu_b = id_ex_i.use_imm ? id_ex_i.imm : rs2_val;

    alu i_alu (
        .op_i (id_ex_i.alu_op),
        .a_i  (rs1_val),
        .b_i  (alu_b),
        .f_o  (alu_f)
    );

    // commit register
    // one valid cycle per instruction since id_ex valid is a pulse
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            commit_o <= '0;
        end else begin
            commit_o.valid <= id_ex_i.valid;
            commit_o.rd    <= id_ex_i.rd;
            commit_o.data  <= alu_f;
        end
    end

endmodule : execute_stage

//--- verilog/rv_core_top.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module rv_core_top (
    input  logic                   clk,
    input  logic                   rst_n_i,

    // one instruction per strobe, never stalled
    input  logic                   instr_valid_i,
    input  logic [`RV_INSTR_W-1:0] instr_i,

    // one record per executed instruction
    output rv_pkg::commit_t        commit_o
);

    // decode to execute stage register
    rv_pkg::id_ex_t  id_ex;

    // commit register, read back as the write port
    rv_pkg::commit_t commit;

    // instruction register, field decode, register read
    decode_stage i_decode_stage (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_i          (commit),
        .id_ex_o       (id_ex)
    );

    // forwarding, alu and the commit register
    execute_stage i_execute_stage (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .id_ex_i  (id_ex),
        .commit_o (commit)
    );

    // result leaves two edges after the strobe was sampled
    assign commit_o = commit;

endmodule : rv_core_top

//--- tests/tb_rv_model.svh
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// one expected commit and the clock edge after which it must show
typedef struct packed {
    rv_pkg::commit_t c;
    logic [63:0]     due;
} expect_t;

// architectural registers as the reference sees them
logic [`RV_XLEN-1:0] shadow_q [`RV_NUM_REGS];

// matches the cleared register file after reset
function automatic void clear_shadow();
    for (int i = 0; i < `RV_NUM_REGS; i++) begin
        shadow_q[i] = '0;
    end
endfunction

// executes one instruction in program order on the shadow registers
// valid low means the opcode is not executed and nothing commits
function automatic rv_pkg::commit_t expected_commit(input logic [31:0] instr);
    rv_pkg::commit_t     res;
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    logic [4:0]          sh;
    logic                alt;
    logic                is_reg;
    res    = '0;
    res.rd = instr[11:7];
    a      = shadow_q[instr[19:15]];
    // opcode bit 5 tells the register form from the immediate form
    is_reg = instr[5];
    alt    = instr[30];
    b      = is_reg ? shadow_q[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
    sh     = b[4:0];
    case (instr[6:0])
        // lui
        7'b0110111: begin
            res.valid = 1'b1;
            res.data  = {instr[31:12], 12'h000};
        end
        7'b0110011, 7'b0010011: begin
            res.valid = 1'b1;
            case (instr[14:12])
                3'b000: res.data = (is_reg && alt) ? a - b : a + b;
                3'b001: res.data = a << sh;
                3'b010: res.data = {31'b0, $signed(a) < $signed(b)};
                3'b011: res.data = {31'b0, a < b};
                3'b100: res.data = a ^ b;
                3'b101: begin
                    // arithmetic shift kept apart so the sign survives
                    if (alt) begin
                        res.data = $signed(a) >>> sh;
                    end else begin
                        res.data = a >> sh;
                    end
                end
                3'b110: res.data = a | b;
                default: res.data = a & b;
            endcase
        end
        default: res.valid = 1'b0;
    endcase
    // x0 keeps reading zero
    if (res.valid && (res.rd != 5'd0)) begin
        shadow_q[res.rd] = res.data;
    end
    return res;
endfunction

`endif

//--- tests/tb_rv_core.sv
`timescale 1ns/10ps
`include "rv_macros.svh"

module tb_rv_core;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 8;
    localparam int DIRECTED_CYCLES = 160;
    localparam int N_RANDOM        = 300;
    localparam int MAX_GAP         = 3;
    localparam int N_BURST         = 100;
    localparam int DRAIN_CYCLES    = 8;
    // worst case length of the whole run in cycles
    localparam int RUN_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + N_RANDOM * (1 + MAX_GAP)
                                 + N_BURST + DRAIN_CYCLES;
    localparam int WATCHDOG_NS = 2 * RUN_CYCLES * CLK_PERIOD + 1000;

    logic                   clk;
    logic                   rst_n_i;
    logic                   instr_valid_i;
    logic [`RV_INSTR_W-1:0] instr_i;
    rv_pkg::commit_t        commit_o;

    integer seed;
    int     data_errs;
    int     time_errs;
    int     extra_errs;
    int     missing_errs;
    int     n_checked;

    `include "tb_rv_model.svh"

    // commits still in flight with the oldest at the front
    expect_t exp_q[$];

    rv_core_top i_rv_core_top (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .commit_o      (commit_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // alt sets funct7 bit 5 for sub and sra
    function automatic logic [31:0] reg_word(input logic [2:0] f3, input logic alt,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] imm_word(input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    // legal encodings on x0 to x7 so streams depend on each other a lot
    function automatic logic [31:0] rand_instr();
        logic [31:0] r;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        r   = $random(seed);
        f3  = r[11:9];
        alt = r[12] && ((f3 == 3'b000) || (f3 == 3'b101));
        imm = r[31:20];
        case (r[15:13])
            3'd0, 3'd1, 3'd2: return reg_word(f3, alt, {2'b0, r[2:0]}, {2'b0, r[5:3]},
                                              {2'b0, r[8:6]});
            3'd3, 3'd4, 3'd5: begin
                // immediate shifts carry only a 5 bit amount
                if (f3 == 3'b001) imm = {7'h00, imm[4:0]};
                if (f3 == 3'b101) imm = {1'b0, alt, 5'b0, imm[4:0]};
                return imm_word(f3, {2'b0, r[2:0]}, {2'b0, r[5:3]}, imm);
            end
            3'd6: return lui_word({2'b0, r[2:0]}, r[31:12]);
            // load, store, branch, auipc are all dropped in decode
            default: begin
                case (r[17:16])
                    2'd0: return {r[31:7], 7'b0000011};
                    2'd1: return {r[31:7], 7'b0100011};
                    2'd2: return {r[31:7], 7'b1100011};
                    default: return {r[31:7], 7'b0010111};
                endcase
            end
        endcase
    endfunction

    // the DUT samples the strobe at the next edge and commits two edges later
    task automatic issue(input logic [31:0] instr);
        expect_t e;
        @(posedge clk);
        instr_valid_i <= 1'b1;
        instr_i       <= instr;
        e.c   = expected_commit(instr);
        e.due = $time + 3 * CLK_PERIOD;
        if (e.c.valid) exp_q.push_back(e);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid_i <= 1'b0;
            instr_i       <= $random(seed);
        end
    endtask

    // each commit meets the oldest expected one at the falling edge
    always @(negedge clk) begin : compare_commits
        expect_t exp_e;
        time     edge_t;
        edge_t = $time - CLK_PERIOD / 2;
        if (commit_o.valid) begin
            assert (exp_q.size() != 0) else begin
                extra_errs++;
                $display("unexpected commit to x%0d at %0t with no instruction outstanding",
                         commit_o.rd, $time);
            end
            if (exp_q.size() != 0) begin
                exp_e = exp_q.pop_front();
                n_checked++;
                assert ((commit_o.rd == exp_e.c.rd) && (commit_o.data == exp_e.c.data)) else begin
                    data_errs++;
                    $display("[ERROR] %0t: commit x%0d = %h, expected x%0d = %h", $time,
                             commit_o.rd, commit_o.data, exp_e.c.rd, exp_e.c.data);
                end
                assert (edge_t == exp_e.due) else begin
                    time_errs++;
                    $display("[ERROR] %0t: commit to x%0d after edge %0t, expected edge %0t",
                             $time, commit_o.rd, edge_t, exp_e.due);
                end
            end
        end else if (exp_q.size() != 0) begin
            assert (edge_t < exp_q[0].due) else begin
                missing_errs++;
                $display("expected commit to x%0d never arrived, it was due after %0t",
                         exp_q[0].c.rd, exp_q[0].due);
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

    initial begin : stimulus
        int          gap;
        logic [11:0] step;
        seed          = 32'h8f0f_abb8;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        data_errs     = 0;
        time_errs     = 0;
        extra_errs    = 0;
        missing_errs  = 0;
        n_checked     = 0;
        clear_shadow();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        assert (!commit_o.valid) else begin
            extra_errs++;
            $display("commit_o.valid is high right after reset");
        end
        // preload x1 large and x2 small, x3 negative, x4 a shift amount and x5 a pattern
        issue(lui_word(5'd1, 20'h80000));
        issue(imm_word(3'b000, 5'd1, 5'd1, 12'h123));
        issue(lui_word(5'd2, 20'h00001));
        issue(imm_word(3'b000, 5'd2, 5'd2, 12'hfff));
        issue(lui_word(5'd3, 20'hfffff));
        issue(imm_word(3'b000, 5'd3, 5'd3, 12'hffb));
        issue(imm_word(3'b000, 5'd4, 5'd0, 12'd7));
        issue(lui_word(5'd5, 20'h12345));
        issue(imm_word(3'b000, 5'd5, 5'd5, 12'h678));
        idle(2);
        // register-register group
        issue(reg_word(3'b000, 1'b0, 5'd6, 5'd1, 5'd2));
        issue(reg_word(3'b000, 1'b1, 5'd7, 5'd2, 5'd1));
        issue(reg_word(3'b001, 1'b0, 5'd8, 5'd5, 5'd4));
        issue(reg_word(3'b010, 1'b0, 5'd9, 5'd3, 5'd2));
        issue(reg_word(3'b011, 1'b0, 5'd10, 5'd3, 5'd2));
        issue(reg_word(3'b010, 1'b0, 5'd16, 5'd2, 5'd3));
        issue(reg_word(3'b011, 1'b0, 5'd17, 5'd2, 5'd3));
        issue(reg_word(3'b100, 1'b0, 5'd11, 5'd1, 5'd5));
        issue(reg_word(3'b101, 1'b0, 5'd12, 5'd3, 5'd4));
        issue(reg_word(3'b101, 1'b1, 5'd13, 5'd3, 5'd4));
        issue(reg_word(3'b110, 1'b0, 5'd14, 5'd1, 5'd2));
        issue(reg_word(3'b111, 1'b0, 5'd15, 5'd3, 5'd5));
        idle(3);
        // register-immediate group with negative immediates and shifts
        issue(imm_word(3'b000, 5'd18, 5'd3, 12'h800));
        issue(imm_word(3'b010, 5'd19, 5'd2, 12'hfff));
        issue(imm_word(3'b010, 5'd20, 5'd3, 12'hfff));
        issue(imm_word(3'b011, 5'd21, 5'd2, 12'hfff));
        issue(imm_word(3'b011, 5'd22, 5'd3, 12'h005));
        issue(imm_word(3'b100, 5'd23, 5'd1, 12'hfff));
        issue(imm_word(3'b110, 5'd24, 5'd5, 12'h0f0));
        issue(imm_word(3'b111, 5'd25, 5'd3, 12'h7ff));
        issue(imm_word(3'b001, 5'd26, 5'd5, 12'd31));
        issue(imm_word(3'b101, 5'd27, 5'd3, 12'h004));
        issue(imm_word(3'b101, 5'd28, 5'd3, 12'h404));
        idle(2);
        // readers one, two and three behind the same writer
        step = 12'h7c1;
        for (int i = 0; i < 4; i++) begin
            issue(imm_word(3'b000, 5'd6, 5'd6, step));
            issue(reg_word(3'b000, 1'b0, 5'd7, 5'd6, 5'd0));
            issue(reg_word(3'b000, 1'b1, 5'd8, 5'd0, 5'd6));
            issue(reg_word(3'b100, 1'b0, 5'd9, 5'd6, 5'd7));
            issue(reg_word(3'b110, 1'b0, 5'd10, 5'd8, 5'd9));
            step = step + 12'h1f3;
            if (i[0]) idle(1);
        end
        // youngest of two writers wins
        issue(imm_word(3'b000, 5'd11, 5'd0, 12'd5));
        issue(imm_word(3'b000, 5'd11, 5'd0, 12'd9));
        issue(reg_word(3'b000, 1'b0, 5'd12, 5'd11, 5'd0));
        // x0 commits its value but keeps reading zero
        issue(imm_word(3'b000, 5'd0, 5'd1, 12'd5));
        issue(reg_word(3'b000, 1'b0, 5'd29, 5'd0, 5'd0));
        issue(reg_word(3'b110, 1'b0, 5'd30, 5'd0, 5'd0));
        // dropped opcodes must leave x1 and x2 alone
        issue(32'h0000_2083);
        issue(32'h0000_1117);
        issue(reg_word(3'b000, 1'b0, 5'd31, 5'd1, 5'd2));
        idle(4);
        repeat (N_RANDOM) begin
            issue(rand_instr());
            gap = $random(seed) & MAX_GAP;
            if ($random(seed) & 1) gap = 0;
            idle(gap);
        end
        // full rate stream
        repeat (N_BURST) issue(rand_instr());
        idle(DRAIN_CYCLES);
        @(negedge clk);
        $display("checked %0d commits: %0d data, %0d timing, %0d unexpected, %0d missing errors",
                 n_checked, data_errs, time_errs, extra_errs, missing_errs);
        if ((data_errs + time_errs + extra_errs + missing_errs) == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_rv_core

//--- sim.f
+incdir+verilog
+incdir+tests
verilog/rv_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/rv_core_top.sv
tests/tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal -f sim.f --top-module tb_rv_core -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/Vtb_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qxF '** PASS **' sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
